// ==== verilog/apu_pkg.sv ====
package apu_pkg;

	// APB data byte and channel register
	typedef logic [7:0] reg_byte_t;

	// APB register index
	typedef logic [3:0] reg_idx_t;

	// Pulse timer period
	typedef logic [10:0] timer_t;

	// Channel amplitude
	typedef logic [3:0] vol_t;

	// Length counter value and its table index
	typedef logic [7:0] len_t;
	typedef logic [4:0] len_idx_t;

	// Sum of both channels
	typedef logic [4:0] mix_t;

	// Quarter-frame steps, odd ones are half frames
	typedef enum logic [1:0] {
		step0,
		step1,
		step2,
		step3
	} frame_step_e;

endpackage

// ==== verilog/apu_frame_seq.sv ====
`timescale 1ns/1ps

module apu_frame_seq import apu_pkg::*; #(
	parameter int unsigned frame_div = 64
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	output logic apu_tick,
	output logic qframe,
	output logic hframe
);

	localparam int unsigned cnt_w = (frame_div > 1) ? $clog2(frame_div) : 1;

	logic [cnt_w-1:0] div_cnt;
	frame_step_e      step;
	frame_step_e      step_nxt;

	always_comb begin
		case (step)
			step0:   step_nxt = step1;
			step1:   step_nxt = step2;
			step2:   step_nxt = step3;
			default: step_nxt = step0;
		endcase
	end

	// APU clock runs at half the system rate
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			apu_tick <= 1'b0;
		end else begin
			apu_tick <= ~apu_tick;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			div_cnt <= '0;
			step    <= step0;
			qframe  <= 1'b0;
			hframe  <= 1'b0;
		end else if (div_cnt == '0) begin
			div_cnt <= cnt_w'(frame_div - 1);
			step    <= step_nxt;
			qframe  <= 1'b1;
			// Every second quarter frame
			hframe  <= (step == step1) || (step == step3);
		end else begin
			div_cnt <= div_cnt - 1'b1;
			qframe  <= 1'b0;
			hframe  <= 1'b0;
		end
	end

endmodule

// ==== verilog/apu_length_rom.sv ====
`timescale 1ns/1ps

module apu_length_rom import apu_pkg::*; (
	input  len_idx_t idx,
	output len_t     len
);

	// Standard NES length table
	always_comb begin
		case (idx)
			5'd0:    len = 8'd10;
			5'd1:    len = 8'd254;
			5'd2:    len = 8'd20;
			5'd3:    len = 8'd2;
			5'd4:    len = 8'd40;
			5'd5:    len = 8'd4;
			5'd6:    len = 8'd80;
			5'd7:    len = 8'd6;
			5'd8:    len = 8'd160;
			5'd9:    len = 8'd8;
			5'd10:   len = 8'd60;
			5'd11:   len = 8'd10;
			5'd12:   len = 8'd14;
			5'd13:   len = 8'd12;
			5'd14:   len = 8'd26;
			5'd15:   len = 8'd14;
			5'd16:   len = 8'd12;
			5'd17:   len = 8'd16;
			5'd18:   len = 8'd24;
			5'd19:   len = 8'd18;
			5'd20:   len = 8'd48;
			5'd21:   len = 8'd20;
			5'd22:   len = 8'd96;
			5'd23:   len = 8'd22;
			5'd24:   len = 8'd192;
			5'd25:   len = 8'd24;
			5'd26:   len = 8'd72;
			5'd27:   len = 8'd26;
			5'd28:   len = 8'd16;
			5'd29:   len = 8'd28;
			5'd30:   len = 8'd32;
			default: len = 8'd30;
		endcase
	end

endmodule

// ==== verilog/apu_pulse.sv ====
`timescale 1ns/1ps

module apu_pulse import apu_pkg::*; #(
	parameter bit ones_comp = 1'b0
) (
	input  logic      sys_clk,
	input  logic      sys_rst_n,
	input  logic      en,
	input  logic      wr_en,
	input  logic [1:0] wr_idx,
	input  reg_byte_t wr_data,
	input  logic [1:0] rd_idx,
	output reg_byte_t rd_data,
	input  logic      apu_tick,
	input  logic      qframe,
	input  logic      hframe,
	output logic      act,
	output vol_t      amp
);

	reg_byte_t regs [4];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			for (int i = 0; i < 4; i++)
				regs[i] <= '0;
		end else if (!en) begin
			for (int i = 0; i < 4; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	assign rd_data = regs[rd_idx];

	logic [1:0] duty;
	logic       halt;
	logic       const_vol;
	vol_t       vol;
	logic       swp_en;
	logic [2:0] swp_per;
	logic       swp_neg;
	logic [2:0] swp_shift;
	logic       reg1_wr;
	logic       reg3_wr;

	assign duty      = regs[0][7:6];
	assign halt      = regs[0][5];
	assign const_vol = regs[0][4];
	assign vol       = regs[0][3:0];
	assign swp_en    = regs[1][7];
	assign swp_per   = regs[1][6:4];
	assign swp_neg   = regs[1][3];
	assign swp_shift = regs[1][2:0];
	assign reg1_wr   = wr_en && en && (wr_idx == 2'd1);
	assign reg3_wr   = wr_en && en && (wr_idx == 2'd3);

	// Sweep target, carry out of bit 10 flags overflow or underflow
	timer_t      period;
	timer_t      swp_delta;
	logic [11:0] swp_sum;
	logic        swp_ovf;
	logic        swp_mute;
	logic        swp_apply;
	logic [2:0]  swp_div;
	logic        swp_reload;

	assign swp_delta = (period >> swp_shift) ^ {11{swp_neg}};
	assign swp_sum   = {1'b0, period} + {1'b0, swp_delta} + 12'(swp_neg & ~ones_comp);
	assign swp_ovf   = swp_neg ^ swp_sum[11];
	assign swp_mute  = ~swp_neg & swp_sum[11];
	assign swp_apply = hframe && swp_en && (swp_div == '0) && (swp_shift != '0) && !swp_ovf;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			swp_div    <= '0;
			swp_reload <= 1'b0;
		end else if (!en) begin
			swp_div    <= '0;
			swp_reload <= 1'b0;
		end else begin
			if (hframe) begin
				if (swp_reload || swp_div == '0)
					swp_div <= swp_per;
				else
					swp_div <= swp_div - 3'd1;
				swp_reload <= 1'b0;
			end
			if (reg1_wr)
				swp_reload <= 1'b1;
		end
	end

	// Timer and duty sequencer
	timer_t     timer_cnt;
	logic [2:0] seq_step;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			period    <= '0;
			timer_cnt <= '0;
			seq_step  <= '0;
		end else if (!en) begin
			period    <= '0;
			timer_cnt <= '0;
			seq_step  <= '0;
		end else if (reg3_wr) begin
			period    <= {wr_data[2:0], regs[2]};
			timer_cnt <= {wr_data[2:0], regs[2]};
			seq_step  <= '0;
		end else begin
			if (swp_apply)
				period <= swp_sum[10:0];
			if (apu_tick) begin
				if (timer_cnt == '0) begin
					timer_cnt <= period;
					seq_step  <= seq_step - 3'd1;
				end else begin
					timer_cnt <= timer_cnt - 11'd1;
				end
			end
		end
	end

	logic seq_hi;

	always_comb begin
		case (duty)
			2'd0:    seq_hi = (seq_step == 3'b111);
			2'd1:    seq_hi = (seq_step[2:1] == 2'b11);
			2'd2:    seq_hi = seq_step[2];
			default: seq_hi = (seq_step[2:1] != 2'b11);
		endcase
	end

	// Envelope, restarted by a register-3 write
	logic env_start;
	vol_t env_div;
	vol_t env_cnt;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			env_start <= 1'b0;
			env_div   <= '0;
			env_cnt   <= '0;
		end else if (!en) begin
			env_start <= 1'b0;
			env_div   <= '0;
			env_cnt   <= '0;
		end else begin
			if (qframe) begin
				if (env_start) begin
					env_div <= vol;
					env_cnt <= 4'hf;
				end else if (env_div == '0) begin
					env_div <= vol;
					// Wraps to 15 in loop mode
					if (halt || env_cnt != '0)
						env_cnt <= env_cnt - 4'd1;
				end else begin
					env_div <= env_div - 4'd1;
				end
				env_start <= 1'b0;
			end
			if (reg3_wr)
				env_start <= 1'b1;
		end
	end

	// Length counter
	len_t len_cnt;
	len_t len_load;

	apu_length_rom i_len_rom (
		.idx (wr_data[7:3]),
		.len (len_load)
	);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			len_cnt <= '0;
		end else if (!en) begin
			len_cnt <= '0;
		end else if (reg3_wr) begin
			len_cnt <= len_load;
		end else if (hframe && !halt && len_cnt != '0) begin
			len_cnt <= len_cnt - 8'd1;
		end
	end

	logic audible;

	assign act     = en && (len_cnt != '0);
	assign audible = act && seq_hi && !swp_mute && (period[10:3] != '0);
	assign amp     = audible ? (const_vol ? vol : env_cnt) : '0;

endmodule

// ==== verilog/apu_apb_decode.sv ====
`timescale 1ns/1ps

module apu_apb_decode import apu_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       psel,
	input  logic       penable,
	input  logic       pwrite,
	input  reg_idx_t   paddr,
	input  reg_byte_t  pwdata,
	output reg_byte_t  prdata,
	output logic       ch0_wr_en,
	output logic       ch1_wr_en,
	output logic [1:0] wr_idx,
	output reg_byte_t  wr_data,
	output logic [1:0] rd_idx,
	input  reg_byte_t  ch0_rd_data,
	input  reg_byte_t  ch1_rd_data,
	input  logic       ch0_act,
	input  logic       ch1_act,
	output logic       ch0_en,
	output logic       ch1_en
);

	logic       wr_acc;
	logic [1:0] ctrl;

	// Writes land at the end of the access phase
	assign wr_acc    = psel && penable && pwrite;
	assign ch0_wr_en = wr_acc && (paddr[3:2] == 2'b00);
	assign ch1_wr_en = wr_acc && (paddr[3:2] == 2'b01);
	assign wr_idx    = paddr[1:0];
	assign wr_data   = pwdata;
	assign rd_idx    = paddr[1:0];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			ctrl <= '0;
		end else if (wr_acc && paddr == 4'd8) begin
			ctrl <= pwdata[1:0];
		end
	end

	assign ch0_en = ctrl[0];
	assign ch1_en = ctrl[1];

	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			case (paddr)
				4'd0, 4'd1, 4'd2, 4'd3: prdata = ch0_rd_data;
				4'd4, 4'd5, 4'd6, 4'd7: prdata = ch1_rd_data;
				// Status: act bits above the enables
				4'd8:    prdata = {2'b00, ch1_act, ch0_act, 2'b00, ctrl};
				default: prdata = '0;
			endcase
		end
	end

endmodule

// ==== verilog/apu_mixer.sv ====
`timescale 1ns/1ps

module apu_mixer import apu_pkg::*; (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  vol_t amp0,
	input  vol_t amp1,
	output mix_t sample
);

	mix_t sum;

	// Linear mix, no DAC curve
	assign sum = mix_t'(amp0) + mix_t'(amp1);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sample <= '0;
		end else begin
			sample <= sum;
		end
	end

endmodule

// ==== verilog/apu_top.sv ====
`timescale 1ns/1ps

module apu_top import apu_pkg::*; #(
	parameter int unsigned frame_div = 64
) (
	input  logic      sys_clk,
	input  logic      sys_rst_n,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  reg_idx_t  paddr,
	input  reg_byte_t pwdata,
	output reg_byte_t prdata,
	output mix_t      sample
);

	logic       ch0_wr_en;
	logic       ch1_wr_en;
	logic [1:0] wr_idx;
	reg_byte_t  wr_data;
	logic [1:0] rd_idx;
	reg_byte_t  ch0_rd_data;
	reg_byte_t  ch1_rd_data;
	logic       ch0_act;
	logic       ch1_act;
	logic       ch0_en;
	logic       ch1_en;
	logic       apu_tick;
	logic       qframe;
	logic       hframe;
	vol_t       amp0;
	vol_t       amp1;

	apu_apb_decode i_decode (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.ch0_wr_en   (ch0_wr_en),
		.ch1_wr_en   (ch1_wr_en),
		.wr_idx      (wr_idx),
		.wr_data     (wr_data),
		.rd_idx      (rd_idx),
		.ch0_rd_data (ch0_rd_data),
		.ch1_rd_data (ch1_rd_data),
		.ch0_act     (ch0_act),
		.ch1_act     (ch1_act),
		.ch0_en      (ch0_en),
		.ch1_en      (ch1_en)
	);

	apu_frame_seq #(.frame_div(frame_div)) i_frame (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.apu_tick  (apu_tick),
		.qframe    (qframe),
		.hframe    (hframe)
	);

	// Channel 0 negates in ones' complement like the original part
	apu_pulse #(.ones_comp(1'b1)) i_pulse0 (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.en        (ch0_en),
		.wr_en     (ch0_wr_en),
		.wr_idx    (wr_idx),
		.wr_data   (wr_data),
		.rd_idx    (rd_idx),
		.rd_data   (ch0_rd_data),
		.apu_tick  (apu_tick),
		.qframe    (qframe),
		.hframe    (hframe),
		.act       (ch0_act),
		.amp       (amp0)
	);

	apu_pulse #(.ones_comp(1'b0)) i_pulse1 (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.en        (ch1_en),
		.wr_en     (ch1_wr_en),
		.wr_idx    (wr_idx),
		.wr_data   (wr_data),
		.rd_idx    (rd_idx),
		.rd_data   (ch1_rd_data),
		.apu_tick  (apu_tick),
		.qframe    (qframe),
		.hframe    (hframe),
		.act       (ch1_act),
		.amp       (amp1)
	);

	apu_mixer i_mixer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.amp0      (amp0),
		.amp1      (amp1),
		.sample    (sample)
	);

endmodule

// ==== verif/apu_chk.sv ====
`timescale 1ns/1ps

module apu_chk import apu_pkg::*; (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic qframe,
	input logic hframe,
	input logic en,
	input logic act,
	input vol_t amp
);

	bit   hframe_bad = 1'b0;
	bit   qframe_bad = 1'b0;
	bit   amp_bad    = 1'b0;
	bit   act_bad    = 1'b0;
	logic failed;

	assign failed = hframe_bad | qframe_bad | amp_bad | act_bad;

	hframe_in_qframe: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		hframe |-> qframe)
	else begin
		$error("hframe without qframe");
		hframe_bad = 1'b1;
	end

	qframe_one_cycle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		qframe |=> !qframe)
	else begin
		$error("qframe longer than one cycle");
		qframe_bad = 1'b1;
	end

	// Disabled channel is silent and inactive
	amp_off: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!en |-> (amp == '0))
	else begin
		$error("amp nonzero while disabled");
		amp_bad = 1'b1;
	end

	act_off: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!en |-> !act)
	else begin
		$error("act high while disabled");
		act_bad = 1'b1;
	end

endmodule

bind apu_frame_seq apu_chk i_chk (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.qframe    (qframe),
	.hframe    (hframe),
	.en        (1'b1),
	.act       (1'b0),
	.amp       (4'h0)
);

bind apu_pulse apu_chk i_chk (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.qframe    (qframe),
	.hframe    (hframe),
	.en        (en),
	.act       (act),
	.amp       (amp)
);

// ==== verif/apu_tb.sv ====
`timescale 1ns/1ps

module apu_tb import apu_pkg::*; ();

	localparam int frame_div  = 64;
	localparam int hf_cycles  = 2 * frame_div;
	localparam int clk_period = 20;

	logic      sys_clk;
	logic      sys_rst_n;
	logic      psel;
	logic      penable;
	logic      pwrite;
	reg_idx_t  paddr;
	reg_byte_t pwdata;
	reg_byte_t prdata;
	mix_t      sample;

	logic [31:0] lcg_state;
	reg_byte_t   model_regs [2][4];
	logic [1:0]  model_en;
	int          len_table [32] = '{10, 254, 20, 2, 40, 4, 80, 6, 160, 8, 60, 10, 14, 12, 26, 14,
		12, 16, 24, 18, 48, 20, 96, 22, 192, 24, 72, 26, 16, 28, 32, 30};

	apu_top #(.frame_div(frame_div)) i_dut (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.sample    (sample)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(clk_period / 2) sys_clk = ~sys_clk;
	end

	function automatic logic [31:0] rand_word();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {lcg_state[15:0], lcg_state[31:16]};
	endfunction

	task automatic stop_fail(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_error(input string msg);
		stop_fail($sformatf("ERR %0t: %s", $time, msg));
	endtask

	task automatic check_byte(input reg_byte_t got, input reg_byte_t exp, input string what);
		if (got !== exp)
			report_error($sformatf("%s read 0x%02h, expected 0x%02h", what, got, exp));
	endtask

	task automatic check_sample(input mix_t got, input mix_t exp, input string what);
		if (got !== exp)
			report_error($sformatf("%s sample %0d, expected %0d", what, got, exp));
	endtask

	function automatic logic assert_failed();
		return i_dut.i_frame.i_chk.failed | i_dut.i_pulse0.i_chk.failed |
			i_dut.i_pulse1.i_chk.failed;
	endfunction

	always @(negedge sys_clk) begin
		if (assert_failed())
			stop_fail("A bound assertion on the DUT failed");
	end

	// Called 1 ns after a rising edge, returns at the same point
	task automatic bus_write(input reg_idx_t addr, input reg_byte_t data);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(posedge sys_clk);
		#1;
		penable = 1'b1;
		@(posedge sys_clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic read_reg(input reg_idx_t addr, output reg_byte_t data);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(posedge sys_clk);
		#1;
		penable = 1'b1;
		@(negedge sys_clk);
		data = prdata;
		@(posedge sys_clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// Bus write plus model update; a disabled channel holds zeros
	task automatic write_reg(input reg_idx_t idx, input reg_byte_t data);
		bus_write(idx, data);
		if (idx < 4'd8) begin
			if (model_en[idx[2]])
				model_regs[idx[2]][idx[1:0]] = data;
		end else if (idx == 4'd8) begin
			model_en = data[1:0];
			for (int c = 0; c < 2; c++)
				if (!model_en[c])
					for (int r = 0; r < 4; r++)
						model_regs[c][r] = '0;
		end
	endtask

	function automatic reg_byte_t model_read(input reg_idx_t idx);
		if (idx < 4'd8)
			return model_regs[idx[2]][idx[1:0]];
		return '0;
	endfunction

	// Halt and constant volume set, so the tone never expires
	task automatic setup_tone(input int ch, input logic [1:0] duty, input vol_t vol,
		input timer_t period, input reg_byte_t sweep);
		reg_idx_t base;
		base = reg_idx_t'(4 * ch);
		write_reg(base, {duty, 2'b11, vol});
		write_reg(base + 4'd1, sweep);
		write_reg(base + 4'd2, period[7:0]);
		write_reg(base + 4'd3, {len_idx_t'(rand_word()), period[10:8]});
	endtask

	// Allowed set is {0, va, vb, va+vb}; both 0 and va+vb must show up
	task automatic watch_samples(input vol_t va, input vol_t vb, input int cycles,
		input string what);
		mix_t top;
		mix_t exp;
		bit   seen_top;
		bit   seen_zero;
		top       = mix_t'(va) + mix_t'(vb);
		seen_top  = 1'b0;
		seen_zero = 1'b0;
		for (int n = 0; n < cycles; n++) begin
			@(negedge sys_clk);
			exp = top;
			if (sample == '0 || sample == mix_t'(va) || sample == mix_t'(vb))
				exp = sample;
			check_sample(sample, exp, what);
			seen_top  |= (sample == top);
			seen_zero |= (sample == '0);
		end
		@(posedge sys_clk);
		#1;
		if (!seen_top)
			report_error($sformatf("%s sample never reached %0d", what, top));
		else if (!seen_zero)
			report_error($sformatf("%s sample never returned to 0", what));
	endtask

	task automatic readback_test();
		reg_idx_t  idx;
		reg_byte_t data;
		reg_byte_t got;
		write_reg(4'd8, 8'h03);
		for (int n = 0; n < 64; n++) begin
			idx  = reg_idx_t'(rand_word() % 8);
			data = reg_byte_t'(rand_word());
			write_reg(idx, data);
			read_reg(idx, got);
			check_byte(got, model_read(idx), "register readback");
		end
		write_reg(4'd8, 8'h02);
		for (int i = 0; i < 8; i++) begin
			read_reg(reg_idx_t'(i), got);
			check_byte(got, model_read(reg_idx_t'(i)), "readback after channel 0 off");
		end
		read_reg(4'd8, got);
		check_byte(got & 8'hdf, 8'h02, "status after channel 0 off");
		write_reg(4'd8, 8'h00);
		read_reg(4'd8, got);
		check_byte(got, 8'h00, "status with both channels off");
	endtask

	task automatic length_expiry();
		reg_byte_t st;
		len_idx_t  lidx;
		int        len;
		int        elapsed;
		time       t_wr;
		for (int n = 0; n < 3; n++) begin
			write_reg(4'd8, 8'h00);
			write_reg(4'd8, 8'h01);
			write_reg(4'd0, reg_byte_t'(rand_word()) & 8'hdf);
			lidx = len_idx_t'(rand_word());
			len  = len_table[lidx];
			write_reg(4'd3, {lidx, 3'b000});
			t_wr = $time;
			read_reg(4'd8, st);
			check_byte(st, 8'h11, "status after register 3 write");
			elapsed = 0;
			while (st[4]) begin
				if (elapsed > (len + 2) * hf_cycles) begin
					stop_fail("Timeout: channel 0 act never fell after its length load");
				end else begin
					read_reg(4'd8, st);
					elapsed = int'(($time - t_wr) / clk_period);
				end
			end
			check_byte(st, 8'h01, "status after length expiry");
			if (elapsed + hf_cycles < len * hf_cycles || elapsed > (len + 1) * hf_cycles)
				report_error($sformatf("act fell after %0d cycles, expected about %0d",
					elapsed, len * hf_cycles));
		end
	endtask

	task automatic halt_hold();
		reg_byte_t st;
		len_idx_t  lidx;
		int        target;
		write_reg(4'd8, 8'h00);
		write_reg(4'd8, 8'h02);
		write_reg(4'd4, reg_byte_t'(rand_word()) | 8'h20);
		lidx   = len_idx_t'(rand_word());
		target = (len_table[lidx] + 2) * hf_cycles;
		write_reg(4'd7, {lidx, 3'b000});
		for (int cyc = 0; cyc < target; cyc += 2) begin
			read_reg(4'd8, st);
			check_byte(st, 8'h22, "status with halt set");
		end
	endtask

	task automatic constant_volume();
		vol_t v0;
		vol_t v1;
		write_reg(4'd8, 8'h00);
		write_reg(4'd8, 8'h03);
		v0 = vol_t'(rand_word() % 15 + 1);
		v1 = vol_t'(rand_word() % 15 + 1);
		setup_tone(0, 2'd2, v0, timer_t'(rand_word() % 32 + 8), 8'h00);
		setup_tone(1, 2'd2, v1, timer_t'(rand_word() % 32 + 8), 8'h00);
		watch_samples(v0, v1, 8000, "constant volume mix");
	endtask

	task automatic mute_conditions();
		vol_t v0;
		vol_t v1;
		// Channel 0 period below 8
		write_reg(4'd8, 8'h00);
		write_reg(4'd8, 8'h03);
		v0 = vol_t'(rand_word() % 15 + 1);
		v1 = vol_t'(rand_word() % 15 + 1);
		setup_tone(0, 2'd3, v0, timer_t'(rand_word() % 8), 8'h00);
		setup_tone(1, 2'd2, v1, timer_t'(rand_word() % 32 + 8), 8'h00);
		watch_samples(v1, 4'd0, 4000, "short period mute");
		// Channel 1 sweep target past 0x7ff
		write_reg(4'd8, 8'h00);
		write_reg(4'd8, 8'h03);
		v0 = vol_t'(rand_word() % 15 + 1);
		v1 = vol_t'(rand_word() % 15 + 1);
		setup_tone(0, 2'd2, v0, timer_t'(rand_word() % 32 + 8), 8'h00);
		setup_tone(1, 2'd3, v1, 11'h7ff, 8'h81);
		watch_samples(v0, 4'd0, 4000, "sweep overflow mute");
	endtask

	initial begin
		reg_byte_t st;
		sys_rst_n = 1'b0;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		lcg_state = 32'd50;
		model_en  = '0;
		for (int c = 0; c < 2; c++)
			for (int r = 0; r < 4; r++)
				model_regs[c][r] = '0;
		repeat (3) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;
		@(posedge sys_clk);
		#1;
		check_byte(prdata, 8'h00, "idle prdata");
		check_sample(sample, 5'd0, "after reset");
		read_reg(4'd8, st);
		check_byte(st, 8'h00, "status after reset");

		readback_test();
		length_expiry();
		halt_hold();
		constant_volume();
		mute_conditions();

		@(posedge sys_clk);
		if (!assert_failed()) begin
			$display("Done: no errors");
			$finish;
		end else begin
			stop_fail("A bound assertion on the DUT failed");
		end
	end

endmodule

// ==== filelist.f ====
verilog/apu_pkg.sv
verilog/apu_frame_seq.sv
verilog/apu_length_rom.sv
verilog/apu_pulse.sv
verilog/apu_apb_decode.sv
verilog/apu_mixer.sv
verilog/apu_top.sv
verif/apu_chk.sv
verif/apu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= apu_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
RUNFLAGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS)

clean:
	rm -rf $(OBJ_DIR)
